// ==== logic/exec_pkg.sv ====
// Execute stage package with operation, exception and privilege types and stage constants
package exec_pkg;

    //////////////////////////////////////////////////
    // Stage widths and constants
    //////////////////////////////////////////////////

    localparam int XLEN    = 32;
    localparam int TAG_W   = 3;
    localparam int STRB_W  = 4;
    localparam int SHAMT_W = 5;

    // Link increments for full and compressed encodings
    localparam logic [XLEN-1:0] INSTR_STEP  = 32'd4;
    localparam logic [XLEN-1:0] CINSTR_STEP = 32'd2;

    //////////////////////////////////////////////////
    // Resolved operation from decode
    //////////////////////////////////////////////////

    typedef enum logic [4:0] {
        NOP,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        LUI,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        BEQ,
        BNE,
        BLT,
        BLTU,
        BGE,
        BGEU,
        JAL,
        JALR,
        ECALL,
        EBREAK,
        MRET
    } op_e;

    //////////////////////////////////////////////////
    // Trap causes in mcause encoding
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 4'h0,
        ILLEGAL_INSTRUCTION            = 4'h2,
        BREAKPOINT                     = 4'h3,
        ECALL_FROM_UMODE               = 4'h8,
        ECALL_FROM_MMODE               = 4'hB,
        NE                             = 4'hF
    } exc_code_e;

    // Privilege level as in the mstatus MPP field
    typedef enum logic [1:0] {
        USER    = 2'b00,
        MACHINE = 2'b11
    } priv_e;

endpackage

// ==== logic/exec_alu.sv ====
// Integer ALU of the execute stage with link address and memory address sum
module exec_alu (
    input  exec_pkg::op_e                 op_i,
    input  logic [exec_pkg::XLEN-1:0]     pc_i,
    input  logic [exec_pkg::XLEN-1:0]     op_a_i,
    input  logic [exec_pkg::XLEN-1:0]     op_b_i,
    input  logic                          compressed_i,
    output logic [exec_pkg::XLEN-1:0]     alu_result_o
);

    logic [exec_pkg::XLEN-1:0]    sum_result;
    logic [exec_pkg::XLEN-1:0]    sub_result;
    logic [exec_pkg::XLEN-1:0]    link_result;
    logic [exec_pkg::XLEN-1:0]    and_result;
    logic [exec_pkg::XLEN-1:0]    or_result;
    logic [exec_pkg::XLEN-1:0]    xor_result;
    logic [exec_pkg::XLEN-1:0]    sll_result;
    logic [exec_pkg::XLEN-1:0]    srl_result;
    logic [exec_pkg::XLEN-1:0]    sra_result;
    logic [exec_pkg::SHAMT_W-1:0] shamt;
    logic                         less_than;
    logic                         less_than_unsigned;

    //////////////////////////////////////////////////
    // Arithmetic and logic
    //////////////////////////////////////////////////

    assign shamt = op_b_i[exec_pkg::SHAMT_W-1:0];

    always_comb begin
        sum_result  = op_a_i + op_b_i;
        sub_result  = op_a_i - op_b_i;
        and_result  = op_a_i & op_b_i;
        or_result   = op_a_i | op_b_i;
        xor_result  = op_a_i ^ op_b_i;
        sll_result  = op_a_i << shamt;
        srl_result  = op_a_i >> shamt;
        sra_result  = $signed(op_a_i) >>> shamt;

        less_than          = $signed(op_a_i) < $signed(op_b_i);
        less_than_unsigned = op_a_i < op_b_i;
    end

    // Return address for JAL and JALR
    assign link_result = pc_i + (compressed_i ? exec_pkg::CINSTR_STEP : exec_pkg::INSTR_STEP);

    //////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////

    always_comb begin
        unique case (op_i)
            exec_pkg::SUB:                  alu_result_o = sub_result;
            exec_pkg::AND:                  alu_result_o = and_result;
            exec_pkg::OR:                   alu_result_o = or_result;
            exec_pkg::XOR:                  alu_result_o = xor_result;
            exec_pkg::SLL:                  alu_result_o = sll_result;
            exec_pkg::SRL:                  alu_result_o = srl_result;
            exec_pkg::SRA:                  alu_result_o = sra_result;
            exec_pkg::SLT:                  alu_result_o = {31'b0, less_than};
            exec_pkg::SLTU:                 alu_result_o = {31'b0, less_than_unsigned};
            exec_pkg::LUI:                  alu_result_o = op_b_i;
            exec_pkg::JAL, exec_pkg::JALR:  alu_result_o = link_result;
            // ADD, loads and stores share the plain sum
            default:                        alu_result_o = sum_result;
        endcase
    end

endmodule

// ==== logic/exec_lsu.sv ====
// Load/store request generation with word address, byte strobes and store data
module exec_lsu (
    input  exec_pkg::op_e                  op_i,
    input  logic [exec_pkg::XLEN-1:0]      op_a_i,
    input  logic [exec_pkg::XLEN-1:0]      op_b_i,
    input  logic [exec_pkg::XLEN-1:0]      op_c_i,
    output logic [exec_pkg::XLEN-1:0]      mem_addr_o,
    output logic                           mem_read_o,
    output logic [exec_pkg::STRB_W-1:0]    mem_strobe_o,
    output logic [exec_pkg::XLEN-1:0]      mem_wdata_o
);

    logic [exec_pkg::XLEN-1:0] addr_sum;

    assign addr_sum = op_a_i + op_b_i;

    // Word aligned address with the lane picked by the strobes
    assign mem_addr_o = {addr_sum[exec_pkg::XLEN-1:2], 2'b00};

    assign mem_read_o = op_i inside {exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH,
                                     exec_pkg::LHU, exec_pkg::LW};

    //////////////////////////////////////////////////
    // Store lanes
    //////////////////////////////////////////////////

    always_comb begin
        unique case (op_i)
            exec_pkg::SB: begin
                unique case (addr_sum[1:0])
                    2'b11:   mem_strobe_o = 4'b1000;
                    2'b10:   mem_strobe_o = 4'b0100;
                    2'b01:   mem_strobe_o = 4'b0010;
                    default: mem_strobe_o = 4'b0001;
                endcase
            end
            exec_pkg::SH:    mem_strobe_o = addr_sum[1] ? 4'b1100 : 4'b0011;
            exec_pkg::SW:    mem_strobe_o = 4'b1111;
            default:         mem_strobe_o = 4'b0000;
        endcase
    end

    // Narrow stores copy the data to every lane
    always_comb begin
        unique case (op_i)
            exec_pkg::SB: mem_wdata_o = {4{op_c_i[7:0]}};
            exec_pkg::SH: mem_wdata_o = {2{op_c_i[15:0]}};
            default:      mem_wdata_o = op_c_i;
        endcase
    end

endmodule

// ==== logic/exec_flow_ctrl.sv ====
// Flow control with branch decision, jump target, trap raising and tag tracking
module exec_flow_ctrl (
    input  logic                          clk,
    input  logic                          reset_n,
    input  exec_pkg::op_e                 op_i,
    input  logic [exec_pkg::XLEN-1:0]     pc_i,
    input  logic [exec_pkg::XLEN-1:0]     op_a_i,
    input  logic [exec_pkg::XLEN-1:0]     op_b_i,
    input  logic [exec_pkg::XLEN-1:0]     op_c_i,
    input  logic [exec_pkg::TAG_W-1:0]    tag_i,
    input  exec_pkg::priv_e               priv_i,
    input  logic                          sys_reset_i,
    input  logic                          exc_illegal_i,
    input  logic                          exc_misaligned_i,
    output logic                          killed_o,
    output logic                          squash_o,
    output logic                          jump_o,
    output logic [exec_pkg::XLEN-1:0]     jump_target_o,
    output logic                          raise_exception_o,
    output exec_pkg::exc_code_e           exception_code_o,
    output logic                          machine_return_o
);

    logic [exec_pkg::TAG_W-1:0] curr_tag;
    logic [exec_pkg::XLEN-1:0]  jump_sum;
    logic                       take_jump;
    logic                       advance_tag;

    // Instructions from an abandoned path carry a stale tag
    assign killed_o = (tag_i != curr_tag) | sys_reset_i;

    //////////////////////////////////////////////////
    // Branch decision and target
    //////////////////////////////////////////////////

    assign jump_sum = op_a_i + op_b_i;

    always_comb begin
        unique case (op_i)
            exec_pkg::JAL:  jump_target_o = jump_sum;
            exec_pkg::JALR: jump_target_o = {jump_sum[exec_pkg::XLEN-1:1], 1'b0};
            default:        jump_target_o = pc_i + op_c_i;
        endcase
    end

    always_comb begin
        unique case (op_i)
            exec_pkg::BEQ:                  take_jump = op_a_i == op_b_i;
            exec_pkg::BNE:                  take_jump = op_a_i != op_b_i;
            exec_pkg::BLT:                  take_jump = $signed(op_a_i) < $signed(op_b_i);
            exec_pkg::BLTU:                 take_jump = op_a_i < op_b_i;
            exec_pkg::BGE:                  take_jump = $signed(op_a_i) >= $signed(op_b_i);
            exec_pkg::BGEU:                 take_jump = op_a_i >= op_b_i;
            exec_pkg::JAL, exec_pkg::JALR:  take_jump = 1'b1;
            default:                        take_jump = 1'b0;
        endcase
    end

    assign jump_o = take_jump & ~killed_o;

    //////////////////////////////////////////////////
    // Traps and MRET
    //////////////////////////////////////////////////

    always_comb begin
        raise_exception_o = 1'b0;
        machine_return_o  = 1'b0;
        exception_code_o  = exec_pkg::NE;
        if (!killed_o) begin
            if (exc_illegal_i) begin
                raise_exception_o = 1'b1;
                exception_code_o  = exec_pkg::ILLEGAL_INSTRUCTION;
            end
            else if (exc_misaligned_i) begin
                raise_exception_o = 1'b1;
                exception_code_o  = exec_pkg::INSTRUCTION_ADDRESS_MISALIGNED;
            end
            else if (op_i == exec_pkg::ECALL) begin
                raise_exception_o = 1'b1;
                exception_code_o  = (priv_i == exec_pkg::USER) ? exec_pkg::ECALL_FROM_UMODE
                                                               : exec_pkg::ECALL_FROM_MMODE;
            end
            else if (op_i == exec_pkg::EBREAK) begin
                raise_exception_o = 1'b1;
                exception_code_o  = exec_pkg::BREAKPOINT;
            end
            else if (op_i == exec_pkg::MRET) begin
                machine_return_o  = 1'b1;
            end
        end
    end

    // No write-back for killed or trapping instructions
    assign squash_o = killed_o | raise_exception_o;

    //////////////////////////////////////////////////
    // Tag register
    //////////////////////////////////////////////////

    // Any redirect opens a new flow
    assign advance_tag = jump_o | raise_exception_o | machine_return_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            curr_tag <= '0;
        end
        else begin
            curr_tag <= curr_tag + {{(exec_pkg::TAG_W-1){1'b0}}, advance_tag};
        end
    end

endmodule

// ==== logic/exec_retire.sv ====
// Write-back register merging the ALU result with the flow-control squash
module exec_retire (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          stall_i,
    input  exec_pkg::op_e                 op_i,
    input  logic [exec_pkg::XLEN-1:0]     alu_result_i,
    input  logic                          squash_i,
    output logic                          write_enable_o,
    output exec_pkg::op_e                 op_o,
    output logic [exec_pkg::XLEN-1:0]     result_o
);

    logic write_enable;

    // Operations without a destination register never write
    always_comb begin
        unique case (op_i)
            exec_pkg::NOP,
            exec_pkg::SB, exec_pkg::SH, exec_pkg::SW,
            exec_pkg::BEQ, exec_pkg::BNE,
            exec_pkg::BLT, exec_pkg::BLTU,
            exec_pkg::BGE, exec_pkg::BGEU,
            exec_pkg::ECALL, exec_pkg::EBREAK,
            exec_pkg::MRET: write_enable = 1'b0;
            default:        write_enable = ~squash_i;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= 1'b0;
            op_o           <= exec_pkg::NOP;
            result_o       <= '0;
        end
        else if (stall_i) begin
            // Bubble into write-back
            write_enable_o <= 1'b0;
            op_o           <= exec_pkg::NOP;
            result_o       <= '0;
        end
        else begin
            write_enable_o <= write_enable;
            op_o           <= op_i;
            result_o       <= alu_result_i;
        end
    end

endmodule

// ==== logic/exec_stage.sv ====
// Execute stage top connecting ALU, load/store, flow control and retire register
module exec_stage (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [exec_pkg::XLEN-1:0]     pc_i,
    input  logic [exec_pkg::XLEN-1:0]     op_a_i,
    input  logic [exec_pkg::XLEN-1:0]     op_b_i,
    input  logic [exec_pkg::XLEN-1:0]     op_c_i,
    input  exec_pkg::op_e                 op_i,
    input  logic                          compressed_i,
    input  logic [exec_pkg::TAG_W-1:0]    tag_i,
    input  exec_pkg::priv_e               priv_i,
    input  logic                          sys_reset_i,
    input  logic                          stall_i,
    input  logic                          exc_illegal_i,
    input  logic                          exc_misaligned_i,
    output logic                          killed_o,
    output logic                          jump_o,
    output logic [exec_pkg::XLEN-1:0]     jump_target_o,
    output logic                          raise_exception_o,
    output exec_pkg::exc_code_e           exception_code_o,
    output logic                          machine_return_o,
    output logic [exec_pkg::XLEN-1:0]     mem_addr_o,
    output logic                          mem_read_o,
    output logic [exec_pkg::STRB_W-1:0]   mem_strobe_o,
    output logic [exec_pkg::XLEN-1:0]     mem_wdata_o,
    output logic [exec_pkg::XLEN-1:0]     result_o,
    output logic                          write_enable_o,
    output exec_pkg::op_e                 op_o
);

    logic [exec_pkg::XLEN-1:0] alu_result;
    logic                      squash;

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    exec_alu u_alu (
        .op_i         (op_i),
        .pc_i         (pc_i),
        .op_a_i       (op_a_i),
        .op_b_i       (op_b_i),
        .compressed_i (compressed_i),
        .alu_result_o (alu_result)
    );

    exec_lsu u_lsu (
        .op_i         (op_i),
        .op_a_i       (op_a_i),
        .op_b_i       (op_b_i),
        .op_c_i       (op_c_i),
        .mem_addr_o   (mem_addr_o),
        .mem_read_o   (mem_read_o),
        .mem_strobe_o (mem_strobe_o),
        .mem_wdata_o  (mem_wdata_o)
    );

    //////////////////////////////////////////////////
    // Flow control
    //////////////////////////////////////////////////

    exec_flow_ctrl u_flow_ctrl (
        .clk               (clk),
        .reset_n           (reset_n),
        .op_i              (op_i),
        .pc_i              (pc_i),
        .op_a_i            (op_a_i),
        .op_b_i            (op_b_i),
        .op_c_i            (op_c_i),
        .tag_i             (tag_i),
        .priv_i            (priv_i),
        .sys_reset_i       (sys_reset_i),
        .exc_illegal_i     (exc_illegal_i),
        .exc_misaligned_i  (exc_misaligned_i),
        .killed_o          (killed_o),
        .squash_o          (squash),
        .jump_o            (jump_o),
        .jump_target_o     (jump_target_o),
        .raise_exception_o (raise_exception_o),
        .exception_code_o  (exception_code_o),
        .machine_return_o  (machine_return_o)
    );

    // Write-back
    exec_retire u_retire (
        .clk            (clk),
        .reset_n        (reset_n),
        .stall_i        (stall_i),
        .op_i           (op_i),
        .alu_result_i   (alu_result),
        .squash_i       (squash),
        .write_enable_o (write_enable_o),
        .op_o           (op_o),
        .result_o       (result_o)
    );

endmodule

// ==== verification/exec_stage_checker.sv ====
// Execute stage checker with reference rules and concurrent assertions bound into the DUT
module exec_stage_checker (
    input logic                          clk,
    input logic                          reset_n,
    input logic [exec_pkg::XLEN-1:0]     pc_i, op_a_i, op_b_i, op_c_i,
    input exec_pkg::op_e                 op_i,
    input logic                          compressed_i, sys_reset_i, stall_i,
    input logic [exec_pkg::TAG_W-1:0]    tag_i,
    input exec_pkg::priv_e               priv_i,
    input logic                          exc_illegal_i, exc_misaligned_i,
    input logic                          killed_o, jump_o, raise_exception_o, machine_return_o,
    input logic [exec_pkg::XLEN-1:0]     jump_target_o, mem_addr_o, mem_wdata_o, result_o,
    input exec_pkg::exc_code_e           exception_code_o,
    input logic                          mem_read_o, write_enable_o,
    input logic [exec_pkg::STRB_W-1:0]   mem_strobe_o,
    input exec_pkg::op_e                 op_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int                          err_count = 0;
    logic [exec_pkg::TAG_W-1:0]  tag_model;
    logic [exec_pkg::XLEN-1:0]   sum;
    logic [exec_pkg::XLEN-1:0]   exp_target;
    logic [exec_pkg::XLEN-1:0]   exp_wdata;
    logic [exec_pkg::XLEN-1:0]   exp_result_q;
    logic [exec_pkg::STRB_W-1:0] exp_strobe;
    logic [3:0]                  exp_ctrl;
    exec_pkg::exc_code_e         exp_code;
    exec_pkg::op_e               exp_op_q;
    logic                        exp_we_q;
    logic                        kill;
    logic                        take;
    logic                        trap;
    logic                        advance;
    logic                        no_write;

    //////////////////////////////////////////////////
    // Reference rules
    //////////////////////////////////////////////////

    function automatic logic [exec_pkg::XLEN-1:0] ref_result(
        input exec_pkg::op_e             op,
        input logic [exec_pkg::XLEN-1:0] pc,
        input logic [exec_pkg::XLEN-1:0] a,
        input logic [exec_pkg::XLEN-1:0] b,
        input logic                      comp
    );
        case (op)
            exec_pkg::SUB:  return a - b;
            exec_pkg::AND:  return a & b;
            exec_pkg::OR:   return a | b;
            exec_pkg::XOR:  return a ^ b;
            exec_pkg::SLL:  return a << b[4:0];
            exec_pkg::SRL:  return a >> b[4:0];
            exec_pkg::SRA:  return $signed(a) >>> b[4:0];
            exec_pkg::SLT:  return {31'b0, $signed(a) < $signed(b)};
            exec_pkg::SLTU: return {31'b0, a < b};
            exec_pkg::LUI:  return b;
            exec_pkg::JAL, exec_pkg::JALR:
                return pc + (comp ? exec_pkg::CINSTR_STEP : exec_pkg::INSTR_STEP);
            default:        return a + b;
        endcase
    endfunction

    task automatic count_failure(input string msg);
        err_count++;
        $error("%s", msg);
    endtask

    assign sum      = op_a_i + op_b_i;
    assign kill     = (tag_i != tag_model) | sys_reset_i;
    assign trap     = !kill & (exc_illegal_i | exc_misaligned_i
                               | op_i == exec_pkg::ECALL | op_i == exec_pkg::EBREAK);
    assign advance  = !kill & (take | trap | op_i == exec_pkg::MRET);
    assign exp_ctrl = {kill, !kill & take, trap, !kill & !trap & op_i == exec_pkg::MRET};
    assign no_write = op_i inside {exec_pkg::NOP, exec_pkg::SB, exec_pkg::SH, exec_pkg::SW,
                                   exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT, exec_pkg::BLTU,
                                   exec_pkg::BGE, exec_pkg::BGEU, exec_pkg::ECALL,
                                   exec_pkg::EBREAK, exec_pkg::MRET};

    always_comb begin
        case (op_i)
            exec_pkg::BEQ:  take = op_a_i == op_b_i;
            exec_pkg::BNE:  take = op_a_i != op_b_i;
            exec_pkg::BLT:  take = $signed(op_a_i) < $signed(op_b_i);
            exec_pkg::BLTU: take = op_a_i < op_b_i;
            exec_pkg::BGE:  take = !($signed(op_a_i) < $signed(op_b_i));
            exec_pkg::BGEU: take = !(op_a_i < op_b_i);
            exec_pkg::JAL, exec_pkg::JALR: take = 1'b1;
            default:        take = 1'b0;
        endcase
        case (op_i)
            exec_pkg::JAL:  exp_target = sum;
            exec_pkg::JALR: exp_target = sum & ~32'd1;
            default:        exp_target = pc_i + op_c_i;
        endcase
    end

    // Cause priority is illegal, misaligned, then the system calls
    always_comb begin
        if (exc_illegal_i)
            exp_code = exec_pkg::ILLEGAL_INSTRUCTION;
        else if (exc_misaligned_i)
            exp_code = exec_pkg::INSTRUCTION_ADDRESS_MISALIGNED;
        else if (op_i == exec_pkg::ECALL)
            exp_code = (priv_i == exec_pkg::MACHINE) ? exec_pkg::ECALL_FROM_MMODE
                                                     : exec_pkg::ECALL_FROM_UMODE;
        else
            exp_code = exec_pkg::BREAKPOINT;
    end

    always_comb begin
        case (op_i)
            exec_pkg::SB: exp_strobe = 4'b0001 << sum[1:0];
            exec_pkg::SH: exp_strobe = sum[1] ? 4'b1100 : 4'b0011;
            exec_pkg::SW: exp_strobe = 4'b1111;
            default:      exp_strobe = 4'b0000;
        endcase
        case (op_i)
            exec_pkg::SB: exp_wdata = {4{op_c_i[7:0]}};
            exec_pkg::SH: exp_wdata = {2{op_c_i[15:0]}};
            default:      exp_wdata = op_c_i;
        endcase
    end

    // Expected write-back one cycle on with the same reset values as the stage
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_model    <= '0;
            exp_result_q <= '0;
            exp_we_q     <= 1'b0;
            exp_op_q     <= exec_pkg::NOP;
        end
        else begin
            tag_model    <= tag_model + {{(exec_pkg::TAG_W-1){1'b0}}, advance};
            exp_result_q <= stall_i ? '0 : ref_result(op_i, pc_i, op_a_i, op_b_i, compressed_i);
            exp_we_q     <= !stall_i & !no_write & !kill & !trap;
            exp_op_q     <= stall_i ? exec_pkg::NOP : op_i;
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////

    a_wb: assert property (@(posedge clk)
            {write_enable_o, op_o, result_o} == {exp_we_q, exp_op_q, exp_result_q})
        else count_failure($sformatf("FAILED write-back: expected %h, actual %h",
            $sampled({exp_we_q, exp_op_q, exp_result_q}),
            $sampled({write_enable_o, op_o, result_o})));

    a_stall: assert property (@(posedge clk) disable iff (!reset_n)
            $past(stall_i) && $past(reset_n) |-> !write_enable_o && op_o == exec_pkg::NOP
                                                  && result_o == '0)
        else count_failure("Stall did not put an empty bubble into write-back");

    a_ctrl: assert property (@(posedge clk) disable iff (!reset_n)
            {killed_o, jump_o, raise_exception_o, machine_return_o} == exp_ctrl)
        else count_failure($sformatf("FAILED flow control: expected %b, actual %b",
            $sampled(exp_ctrl),
            $sampled({killed_o, jump_o, raise_exception_o, machine_return_o})));

    a_target: assert property (@(posedge clk) disable iff (!reset_n)
            op_i inside {[exec_pkg::BEQ:exec_pkg::JALR]} |-> jump_target_o == exp_target)
        else count_failure($sformatf("FAILED jump target: expected %h, actual %h",
            $sampled(exp_target), $sampled(jump_target_o)));

    a_code: assert property (@(posedge clk) disable iff (!reset_n)
            trap |-> exception_code_o == exp_code)
        else count_failure($sformatf("FAILED exception code: expected %h, actual %h",
            $sampled(exp_code), $sampled(exception_code_o)));

    a_mem: assert property (@(posedge clk) disable iff (!reset_n)
            {mem_addr_o, mem_read_o, mem_strobe_o} == {sum & ~32'd3,
                op_i inside {[exec_pkg::LB:exec_pkg::LW]}, exp_strobe})
        else count_failure($sformatf("FAILED memory request: expected %h, actual %h",
            $sampled({sum & ~32'd3, op_i inside {[exec_pkg::LB:exec_pkg::LW]}, exp_strobe}),
            $sampled({mem_addr_o, mem_read_o, mem_strobe_o})));

    a_wdata: assert property (@(posedge clk) disable iff (!reset_n)
            op_i inside {exec_pkg::SB, exec_pkg::SH, exec_pkg::SW} |-> mem_wdata_o == exp_wdata)
        else count_failure($sformatf("FAILED store data: expected %h, actual %h",
            $sampled(exp_wdata), $sampled(mem_wdata_o)));

endmodule

// ==== verification/exec_stage_tb.sv ====
// Execute stage testbench with LFSR stimulus, tag tracking and per-test reporting
module exec_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                          clk = 1'b0;
    logic                          reset_n;
    logic [exec_pkg::XLEN-1:0]     pc_i;
    logic [exec_pkg::XLEN-1:0]     op_a_i;
    logic [exec_pkg::XLEN-1:0]     op_b_i;
    logic [exec_pkg::XLEN-1:0]     op_c_i;
    exec_pkg::op_e                 op_i;
    logic                          compressed_i;
    logic [exec_pkg::TAG_W-1:0]    tag_i;
    exec_pkg::priv_e               priv_i;
    logic                          sys_reset_i;
    logic                          stall_i;
    logic                          exc_illegal_i;
    logic                          exc_misaligned_i;
    logic                          killed_o;
    logic                          jump_o;
    logic [exec_pkg::XLEN-1:0]     jump_target_o;
    logic                          raise_exception_o;
    exec_pkg::exc_code_e           exception_code_o;
    logic                          machine_return_o;
    logic [exec_pkg::XLEN-1:0]     mem_addr_o;
    logic                          mem_read_o;
    logic [exec_pkg::STRB_W-1:0]   mem_strobe_o;
    logic [exec_pkg::XLEN-1:0]     mem_wdata_o;
    logic [exec_pkg::XLEN-1:0]     result_o;
    logic                          write_enable_o;
    exec_pkg::op_e                 op_o;

    logic [31:0]                   lfsr = 32'd21;
    logic [exec_pkg::TAG_W-1:0]    tag_model;
    logic [exec_pkg::TAG_W-1:0]    old_tag;
    logic                          redirect;
    int                            tests_run;
    int                            tests_passed;
    int                            errs_before;
    int                            tries;

    exec_stage UUT (.*);

    bind exec_stage exec_stage_checker u_checker (.*);

    always #5 clk = ~clk;

    // Galois LFSR over x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Drive one instruction and watch for a redirect just before the edge
    task automatic issue(input exec_pkg::op_e op, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] c, input logic stale);
        op_i   = op;
        op_a_i = a;
        op_b_i = b;
        op_c_i = c;
        pc_i   = rand_bits(31) << 1;
        tag_i  = stale ? old_tag : tag_model;
        #7;
        redirect = jump_o | raise_exception_o | machine_return_o;
        if (redirect) begin
            old_tag = tag_model;
            tag_model++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        int errs;
        issue(exec_pkg::NOP, '0, '0, '0, 1'b0);
        errs = UUT.u_checker.err_count - errs_before;
        tests_run++;
        if (errs == 0)
            tests_passed++;
        $display("%-10s done, %0d assertion failures", name, errs);
        errs_before = UUT.u_checker.err_count;
    endtask

    initial begin
        reset_n          = 1'b0;
        pc_i             = '0;
        op_a_i           = '0;
        op_b_i           = '0;
        op_c_i           = '0;
        op_i             = exec_pkg::NOP;
        compressed_i     = 1'b0;
        tag_i            = '0;
        priv_i           = exec_pkg::MACHINE;
        sys_reset_i      = 1'b0;
        stall_i          = 1'b0;
        exc_illegal_i    = 1'b0;
        exc_misaligned_i = 1'b0;
        tag_model        = '0;
        old_tag          = '0;
        tests_run        = 0;
        tests_passed     = 0;
        errs_before      = 0;
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;
        finish_test("reset");

        for (int op = exec_pkg::ADD; op <= exec_pkg::LUI; op++) begin
            repeat (4) issue(exec_pkg::op_e'(op), rand_bits(32), rand_bits(32), '0, 1'b0);
        end
        finish_test("alu");

        // Every lane offset for every load and store
        for (int op = exec_pkg::LB; op <= exec_pkg::SW; op++) begin
            for (int lo = 0; lo < 4; lo++) begin
                issue(exec_pkg::op_e'(op), (rand_bits(30) << 2) | 32'(lo),
                      rand_bits(30) << 2, rand_bits(32), 1'b0);
            end
        end
        finish_test("memory");

        for (int op = exec_pkg::BEQ; op <= exec_pkg::BGEU; op++) begin
            issue(exec_pkg::op_e'(op), rand_bits(32), rand_bits(32), rand_bits(32), 1'b0);
            issue(exec_pkg::op_e'(op), 32'h0000_1234, 32'h0000_1234, rand_bits(32), 1'b0);
        end
        tries    = 0;
        redirect = 1'b0;
        while (!redirect && tries < 32) begin
            issue(exec_pkg::BLT, rand_bits(32), rand_bits(32), rand_bits(32), 1'b0);
            tries++;
        end
        if (!redirect) begin
            $display("Timeout: no taken branch within %0d instructions", tries);
            $display("Test FAILED");
            $finish;
        end
        // Wrong-path instruction still carries the tag from before the jump
        issue(exec_pkg::ADD, rand_bits(32), rand_bits(32), '0, 1'b1);
        for (int i = 0; i < 4; i++) begin
            compressed_i = i[0];
            issue(exec_pkg::JAL, rand_bits(32), rand_bits(32), '0, 1'b0);
            issue(exec_pkg::JALR, rand_bits(32), rand_bits(32), '0, 1'b0);
        end
        compressed_i = 1'b0;
        finish_test("branch");

        for (int i = 0; i < 16; i++) begin
            exc_illegal_i    = i[0];
            exc_misaligned_i = i[1];
            priv_i           = i[2] ? exec_pkg::MACHINE : exec_pkg::USER;
            issue(i[3] ? exec_pkg::ECALL : exec_pkg::EBREAK, rand_bits(32), '0, '0, 1'b0);
            issue(exec_pkg::MRET, rand_bits(32), '0, '0, 1'b0);
            issue(exec_pkg::ADD, rand_bits(32), rand_bits(32), '0, 1'b0);
        end
        exc_illegal_i    = 1'b0;
        exc_misaligned_i = 1'b0;
        sys_reset_i      = 1'b1;
        issue(exec_pkg::ADD, rand_bits(32), rand_bits(32), '0, 1'b0);
        issue(exec_pkg::JAL, rand_bits(32), rand_bits(32), '0, 1'b0);
        sys_reset_i      = 1'b0;
        finish_test("exception");

        // Each stall follows a live write-back so a held value would differ from the bubble
        for (int i = 0; i < 4; i++) begin
            stall_i = 1'b0;
            issue(exec_pkg::ADD, rand_bits(32), rand_bits(32), '0, 1'b0);
            stall_i = 1'b1;
            issue(exec_pkg::ADD, rand_bits(32), rand_bits(32), '0, 1'b0);
        end
        stall_i = 1'b0;
        finish_test("stall");

        $display("%0d tests run, %0d passed, %0d assertion failures",
                 tests_run, tests_passed, UUT.u_checker.err_count);
        if (UUT.u_checker.err_count == 0) begin
            $display("Test OK");
        end
        else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
logic/exec_pkg.sv
logic/exec_alu.sv
logic/exec_lsu.sv
logic/exec_flow_ctrl.sv
logic/exec_retire.sv
logic/exec_stage.sv
verification/exec_stage_checker.sv
verification/exec_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_stage_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
